/* Bender.yml */
package:
  name: execute_stage

sources:
  - logic/rv_isa_pkg.sv
  - logic/exec_pipe_pkg.sv
  - logic/credit_stage.sv
  - logic/operand_forward.sv
  - logic/alu_unit.sv
  - logic/branch_resolve.sv
  - logic/mem_access_gen.sv
  - logic/execute_stage.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_execute_stage.sv

/* files.f */
+incdir+verification
logic/rv_isa_pkg.sv
logic/exec_pipe_pkg.sv
logic/credit_stage.sv
logic/operand_forward.sv
logic/alu_unit.sv
logic/branch_resolve.sv
logic/mem_access_gen.sv
logic/execute_stage.sv
verification/tb_execute_stage.sv

/* logic/alu_unit.sv */
// ##############################
// RV32I integer ALU. Combinational,
// ten operations selected by op.
// Shift amounts come from b[4:0].
// ##############################
module alu_unit
  import rv_isa_pkg::*;
(
  input  word_t  a,
  input  word_t  b,
  input  aluop_t op,
  output word_t  y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_AND:  y = a & b;
      ALU_OR:   y = a | b;
      ALU_XOR:  y = a ^ b;
      ALU_SLL:  y = a << shamt;
      ALU_SRL:  y = a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:  y = word_t'($signed(a) >>> shamt);
      ALU_SLT:  y = word_t'($signed(a) < $signed(b));
      ALU_SLTU: y = word_t'(a < b);
      default:  y = '0;
    endcase
  end

endmodule

/* logic/branch_resolve.sv */
// ##############################
// Resolves branches and jumps for
// the instruction at the head of
// the issue buffer. Operands are
// the forwarded rs1 / rs2 values.
// ##############################
module branch_resolve
  import rv_isa_pkg::*;
  import exec_pipe_pkg::*;
(
  input  dec_ex_t instr,
  input  word_t   rs1_val,
  input  word_t   rs2_val,
  output logic    taken,
  output word_t   resolved_addr,
  output word_t   jump_addr
);

  logic  eq;
  logic  lt;
  logic  ltu;
  logic  cond;
  word_t jump_base;
  word_t jump_sum;

  assign eq  = (rs1_val == rs2_val);
  assign lt  = ($signed(rs1_val) < $signed(rs2_val));
  assign ltu = (rs1_val < rs2_val);

  always_comb begin
    case (instr.branch_type)
      BEQ:     cond = eq;
      BNE:     cond = !eq;
      BLT:     cond = lt;
      BGE:     cond = !lt;
      BLTU:    cond = ltu;
      BGEU:    cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  assign taken         = instr.branch_instr & cond;
  assign resolved_addr = taken ? (instr.pc + instr.br_imm) : instr.pc4;

  assign jump_base = (instr.j_sel == J_PC) ? instr.pc : rs1_val;
  assign jump_sum  = jump_base + instr.j_offset;
  // JALR clears bit 0 of the target
  assign jump_addr = {jump_sum[31:1], 1'b0};

endmodule

/* logic/credit_stage.sv */
// ##############################
// Buffered pipeline stage with
// credit flow control. Upstream
// pushes only while it holds a
// credit, credit_ret gives one back
// per popped entry. The head leaves
// while the downstream count is set.
// ##############################
module credit_stage #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 2,
  parameter int  CREDITS   = 2
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     credit_ret,
  input  logic     kill,
  output logic     out_valid,
  output payload_t out_data,
  output logic     out_killed,
  input  logic     credit_in
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int CRD_W = $clog2(CREDITS + 1);

  payload_t         mem [DEPTH];
  logic [DEPTH-1:0] killed;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CRD_W-1:0] credits;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign pop        = (count != '0) && (credits != '0);
  assign out_valid  = pop;
  assign out_data   = mem[rd_ptr];
  // Head leaving during a flush is killed too
  assign out_killed = killed[rd_ptr] | kill;

  always_ff @(posedge CLK) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credits    <= CRD_W'(CREDITS);
      killed     <= '0;
      credit_ret <= 1'b0;
    end else begin
      credit_ret <= pop;
      if (kill) begin
        killed <= '1;
      end
      // New entry is not part of the flushed set
      if (in_valid) begin
        killed[wr_ptr] <= 1'b0;
        wr_ptr         <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count   <= count + CNT_W'(in_valid) - CNT_W'(pop);
      credits <= credits + CRD_W'(credit_in) - CRD_W'(pop);
    end
  end

  a_no_push_full: assert property (@(posedge CLK) disable iff (!nRST)
    in_valid |-> (count < DEPTH));

  a_credit_bound: assert property (@(posedge CLK) disable iff (!nRST)
    credits <= CRD_W'(CREDITS));

endmodule

/* logic/exec_pipe_pkg.sv */
// ##############################
// Records passed between decode,
// execute and memory, plus the
// bypass state carried with each
// decoded instruction.
// Import with exec_pipe_pkg::*.
// ##############################
package exec_pipe_pkg;

  import rv_isa_pkg::*;

  // Operand source for rs1 / rs2
  typedef enum logic [1:0] {
    FWD_RF = 2'd0,
    FWD_M  = 2'd1,
    FWD_W  = 2'd2
  } fwd_sel_t;

  typedef enum logic {
    A_RS1 = 1'b0,
    A_PC  = 1'b1
  } a_sel_t;

  typedef enum logic {
    B_RS2 = 1'b0,
    B_IMM = 1'b1
  } b_sel_t;

  // Jump base, pc for JAL and rs1 for JALR
  typedef enum logic {
    J_RS1 = 1'b0,
    J_PC  = 1'b1
  } j_sel_t;

  typedef struct packed {
    fwd_sel_t rs1_sel;
    fwd_sel_t rs2_sel;
    word_t    mem_data;
    word_t    wb_data;
  } bypass_t;

  typedef struct packed {
    word_t    pc;
    word_t    pc4;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    a_sel_t   alu_a_sel;
    b_sel_t   alu_b_sel;
    aluop_t   aluop;
    load_t    load_type;
    logic     dren;
    logic     dwen;
    logic     wen;
    reg_idx_t reg_rd;
    logic     branch_instr;
    branch_t  branch_type;
    word_t    br_imm;
    logic     jump_instr;
    j_sel_t   j_sel;
    word_t    j_offset;
    bypass_t  bypass;
  } dec_ex_t;

  // alu_out doubles as the memory address
  typedef struct packed {
    word_t    alu_out;
    word_t    store_wdata;
    byte_en_t byte_en;
    load_t    load_type;
    logic     dren;
    logic     dwen;
    logic     wen;
    reg_idx_t reg_rd;
    logic     branch_instr;
    logic     branch_taken;
    word_t    resolved_addr;
    logic     jump_instr;
    word_t    jump_addr;
    word_t    pc4;
  } ex_mem_t;

endpackage

/* logic/execute_stage.sv */
// ##############################
// Integer execute stage. Decoded
// instructions queue in u_issue,
// are computed at its head and the
// results queue in u_result for
// the memory stage. Credits on both
// sides, flush kills u_issue.
// ##############################
module execute_stage
  import rv_isa_pkg::*;
  import exec_pipe_pkg::*;
#(
  parameter int IN_DEPTH    = 2,
  parameter int MEM_CREDITS = 2
) (
  input  logic    CLK,
  input  logic    nRST,
  input  logic    flush,
  input  logic    in_valid,
  input  dec_ex_t in_instr,
  output logic    in_credit,
  output logic    out_valid,
  output ex_mem_t out_result,
  input  logic    out_credit
);

  dec_ex_t  head;
  logic     head_valid;
  logic     head_killed;
  logic     result_credit;
  word_t    rs1_val;
  word_t    rs2_val;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_y;
  logic     taken;
  word_t    resolved_addr;
  word_t    jump_addr;
  byte_en_t byte_en;
  ex_mem_t  result;

  credit_stage #(
    .payload_t (dec_ex_t),
    .DEPTH     (IN_DEPTH),
    .CREDITS   (MEM_CREDITS)
  ) u_issue (
    .CLK        (CLK),
    .nRST       (nRST),
    .in_valid   (in_valid),
    .in_data    (in_instr),
    .credit_ret (in_credit),
    .kill       (flush),
    .out_valid  (head_valid),
    .out_data   (head),
    .out_killed (head_killed),
    .credit_in  (result_credit)
  );

  operand_forward u_fwd (
    .instr   (head),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .alu_a   (alu_a),
    .alu_b   (alu_b)
  );

  alu_unit u_alu (
    .a  (alu_a),
    .b  (alu_b),
    .op (head.aluop),
    .y  (alu_y)
  );

  branch_resolve u_branch (
    .instr         (head),
    .rs1_val       (rs1_val),
    .rs2_val       (rs2_val),
    .taken         (taken),
    .resolved_addr (resolved_addr),
    .jump_addr     (jump_addr)
  );

  mem_access_gen u_mem_gen (
    .load_type (head.load_type),
    .addr_low  (alu_y[1:0]),
    .byte_en   (byte_en)
  );

  // Killed items still travel with their side effects cleared
  always_comb begin
    result.alu_out       = alu_y;
    result.store_wdata   = rs2_val;
    result.byte_en       = byte_en;
    result.load_type     = head.load_type;
    result.dren          = head.dren & ~head_killed;
    result.dwen          = head.dwen & ~head_killed;
    result.wen           = head.wen & ~head_killed;
    result.reg_rd        = head.reg_rd;
    result.branch_instr  = head.branch_instr;
    result.branch_taken  = taken & ~head_killed;
    result.resolved_addr = resolved_addr;
    result.jump_instr    = head.jump_instr & ~head_killed;
    result.jump_addr     = jump_addr;
    result.pc4           = head.pc4;
  end

  // Slots here are what u_issue counts as credits
  credit_stage #(
    .payload_t (ex_mem_t),
    .DEPTH     (MEM_CREDITS),
    .CREDITS   (MEM_CREDITS)
  ) u_result (
    .CLK        (CLK),
    .nRST       (nRST),
    .in_valid   (head_valid),
    .in_data    (result),
    .credit_ret (result_credit),
    .kill       (1'b0),
    .out_valid  (out_valid),
    .out_data   (out_result),
    .out_killed (),
    .credit_in  (out_credit)
  );

endmodule

/* logic/mem_access_gen.sv */
// ##############################
// Byte-lane enables for loads and
// stores, from the access width and
// the low two address bits.
// ##############################
module mem_access_gen
  import rv_isa_pkg::*;
(
  input  load_t      load_type,
  input  logic [1:0] addr_low,
  output byte_en_t   byte_en
);

  always_comb begin
    case (load_type)
      LB, LBU: byte_en = byte_en_t'(4'b0001 << addr_low);
      // Misaligned halfword gets no lanes
      LH, LHU: begin
        if (addr_low[0]) begin
          byte_en = '0;
        end else begin
          byte_en = addr_low[1] ? 4'b1100 : 4'b0011;
        end
      end
      LW:      byte_en = 4'b1111;
      default: byte_en = '0;
    endcase
  end

endmodule

/* logic/operand_forward.sv */
// ##############################
// Applies the bypass selection to
// rs1 and rs2, then picks the two
// ALU operands. Purely
// combinational, fed by the head
// of the issue buffer.
// ##############################
module operand_forward
  import rv_isa_pkg::*;
  import exec_pipe_pkg::*;
(
  input  dec_ex_t instr,
  output word_t   rs1_val,
  output word_t   rs2_val,
  output word_t   alu_a,
  output word_t   alu_b
);

  // Memory stage holds the younger result
  function automatic word_t fwd_value(
    input fwd_sel_t sel,
    input word_t    rf_data,
    input bypass_t  byp
  );
    word_t val;
    if (sel == FWD_M) begin
      val = byp.mem_data;
    end else if (sel == FWD_W) begin
      val = byp.wb_data;
    end else begin
      val = rf_data;
    end
    return val;
  endfunction

  assign rs1_val = fwd_value(instr.bypass.rs1_sel, instr.rs1_data, instr.bypass);
  assign rs2_val = fwd_value(instr.bypass.rs2_sel, instr.rs2_data, instr.bypass);

  // AUIPC and JAL link use pc on port A
  assign alu_a = (instr.alu_a_sel == A_PC) ? instr.pc : rs1_val;
  assign alu_b = (instr.alu_b_sel == B_IMM) ? instr.imm : rs2_val;

endmodule

/* logic/rv_isa_pkg.sv */
// ##############################
// RV32I base types for the execute
// datapath: data words, register
// indices, lane masks and the ALU,
// load and branch encodings.
// Import with rv_isa_pkg::*.
// ##############################
package rv_isa_pkg;

  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [4:0]          reg_idx_t;
  typedef logic [WORD_W/8-1:0] byte_en_t;

  // ALU function select
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } aluop_t;

  // Same width codes as funct3 of loads and stores
  typedef enum logic [2:0] {
    LB   = 3'b000,
    LH   = 3'b001,
    LW   = 3'b010,
    LBU  = 3'b100,
    LHU  = 3'b101,
    NONE = 3'b111
  } load_t;

  // Branch funct3 codes
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

endpackage

/* verification/tb_vectors.svh */
// ##############################
// Stimulus rows for the execute
// stage testbench. Each row holds a
// decoded instruction, a flush flag
// and the expected result fields.
// ##############################
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
  dec_ex_t  stim;
  logic     flush;
  word_t    alu;
  byte_en_t be;
  logic     taken;
  word_t    res;
  word_t    jmp;
  word_t    st;
} vec_t;

vec_t vecs[$];

// Plain register-writing instruction at pc 0x100
function automatic dec_ex_t ins(aluop_t op, word_t rs1, word_t rs2, word_t imm, logic use_imm);
  dec_ex_t t;
  t = '0;
  t.pc = 32'h100;
  t.pc4 = 32'h104;
  t.rs1_data = rs1;
  t.rs2_data = rs2;
  t.imm = imm;
  t.alu_a_sel = A_RS1;
  t.alu_b_sel = use_imm ? B_IMM : B_RS2;
  t.aluop = op;
  t.load_type = NONE;
  t.wen = 1'b1;
  t.reg_rd = 5'd3;
  t.branch_type = BEQ;
  t.br_imm = 32'h40;
  t.j_sel = J_PC;
  return t;
endfunction

task automatic add_vec(dec_ex_t s, logic fl, word_t alu, byte_en_t be, logic tk,
                       word_t res, word_t jmp, word_t st);
  vec_t v;
  v.stim = s;
  v.flush = fl;
  v.alu = alu;
  v.be = be;
  v.taken = tk;
  v.res = res;
  v.jmp = jmp;
  v.st = st;
  vecs.push_back(v);
endtask

// Branch with br_imm 0x40, target 0x140 when taken
task automatic add_branch(branch_t bt, word_t a, word_t b, word_t sum, logic tk);
  dec_ex_t t;
  t = ins(ALU_ADD, a, b, 32'h0, 1'b0);
  t.branch_instr = 1'b1;
  t.branch_type = bt;
  add_vec(t, 1'b0, sum, 4'h0, tk, tk ? 32'h140 : 32'h104, 32'h100, b);
endtask

`endif

/* verification/tb_execute_stage.sv */
// ##############################
// Testbench for execute_stage.
// Applies the vector table with
// input credits, returns memory
// credits at random and checks
// each result in order.
// ##############################
module tb_execute_stage
  import rv_isa_pkg::*;
  import exec_pipe_pkg::*;
();

  `include "tb_vectors.svh"

  localparam int IN_DEPTH    = 2;
  localparam int MEM_CREDITS = 2;
  localparam int MAX_CYCLES  = 5000;

  logic    CLK;
  logic    nRST;
  logic    flush;
  logic    in_valid;
  dec_ex_t in_instr;
  logic    in_credit;
  logic    out_valid;
  ex_mem_t out_result;
  logic    out_credit;
  logic [31:0] rng = 32'h63d1;

  execute_stage #(.IN_DEPTH(IN_DEPTH), .MEM_CREDITS(MEM_CREDITS)) dut_i (
    .CLK(CLK), .nRST(nRST), .flush(flush), .in_valid(in_valid), .in_instr(in_instr),
    .in_credit(in_credit), .out_valid(out_valid), .out_result(out_result),
    .out_credit(out_credit)
  );

  always #4 CLK = ~CLK;

  function automatic logic [31:0] next_random();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng;
  endfunction

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  endtask

  task automatic build_vectors();
    dec_ex_t  t;
    load_t    lt [6] = '{LB, LBU, LH, LHU, LW, NONE};
    byte_en_t be_tab [6][4] = '{'{4'h1, 4'h2, 4'h4, 4'h8}, '{4'h1, 4'h2, 4'h4, 4'h8},
                                '{4'h3, 4'h0, 4'hc, 4'h0}, '{4'h3, 4'h0, 4'hc, 4'h0},
                                '{4'hf, 4'hf, 4'hf, 4'hf}, '{4'h0, 4'h0, 4'h0, 4'h0}};
    add_vec(ins(ALU_ADD, 5, 7, 0, 0), 0, 32'hc, 0, 0, 32'h104, 32'h100, 7);
    add_vec(ins(ALU_SUB, 5, 9, 7, 1), 0, 32'hffff_fffe, 0, 0, 32'h104, 32'h100, 9);
    add_vec(ins(ALU_AND, 32'hf0f0, 32'hff00, 0, 0), 0, 32'hf000, 0, 0, 32'h104, 32'h100,
            32'hff00);
    add_vec(ins(ALU_OR, 32'hf0f0, 0, 32'h0f0f, 1), 0, 32'hffff, 0, 0, 32'h104, 32'h100, 0);
    add_vec(ins(ALU_XOR, 32'hffff, 32'h0f0f, 0, 0), 0, 32'hf0f0, 0, 0, 32'h104, 32'h100,
            32'h0f0f);
    add_vec(ins(ALU_SLL, 1, 0, 32'h24, 1), 0, 32'h10, 0, 0, 32'h104, 32'h100, 0);
    add_vec(ins(ALU_SRL, 32'h8000_0000, 4, 0, 0), 0, 32'h0800_0000, 0, 0, 32'h104,
            32'h100, 4);
    add_vec(ins(ALU_SRA, 32'h8000_0000, 4, 0, 0), 0, 32'hf800_0000, 0, 0, 32'h104,
            32'h100, 4);
    add_vec(ins(ALU_SLT, 32'hffff_ffff, 1, 0, 0), 0, 32'h1, 0, 0, 32'h104, 32'h100, 1);
    add_vec(ins(ALU_SLTU, 32'hffff_ffff, 1, 0, 0), 0, 32'h0, 0, 0, 32'h104, 32'h100, 1);
    // AUIPC style, pc on port A
    t = ins(ALU_ADD, 0, 0, 32'h1000, 1);
    t.alu_a_sel = A_PC;
    add_vec(t, 0, 32'h1100, 0, 0, 32'h104, 32'h100, 0);
    t = ins(ALU_ADD, 1, 2, 0, 0);
    t.bypass.mem_data = 32'h10;
    t.bypass.wb_data = 32'h20;
    t.bypass.rs1_sel = FWD_M;
    add_vec(t, 0, 32'h12, 0, 0, 32'h104, 32'h100, 2);
    t.bypass.rs1_sel = FWD_W;
    t.bypass.rs2_sel = FWD_M;
    add_vec(t, 0, 32'h30, 0, 0, 32'h104, 32'h100, 32'h10);
    t.bypass.rs1_sel = FWD_RF;
    t.bypass.rs2_sel = FWD_W;
    add_vec(t, 0, 32'h21, 0, 0, 32'h104, 32'h100, 32'h20);
    add_branch(BEQ, 3, 3, 6, 1);
    add_branch(BEQ, 3, 4, 7, 0);
    add_branch(BNE, 3, 4, 7, 1);
    add_branch(BNE, 3, 3, 6, 0);
    add_branch(BLT, 32'hffff_ffff, 1, 0, 1);
    add_branch(BLT, 1, 32'hffff_ffff, 0, 0);
    add_branch(BGE, 1, 32'hffff_ffff, 0, 1);
    add_branch(BGE, 32'hffff_ffff, 1, 0, 0);
    add_branch(BLTU, 1, 32'hffff_ffff, 0, 1);
    add_branch(BLTU, 32'hffff_ffff, 1, 0, 0);
    add_branch(BGEU, 32'hffff_ffff, 1, 0, 1);
    add_branch(BGEU, 1, 32'hffff_ffff, 0, 0);
    t = ins(ALU_ADD, 32'h2003, 0, 4, 1);
    t.jump_instr = 1'b1;
    t.j_offset = 32'h21;
    add_vec(t, 0, 32'h2007, 0, 0, 32'h104, 32'h120, 0);
    t.j_sel = J_RS1;
    t.j_offset = 32'h10;
    add_vec(t, 0, 32'h2007, 0, 0, 32'h104, 32'h2012, 0);
    for (int i = 0; i < 6; i++) begin
      for (int off = 0; off < 4; off++) begin
        t = ins(ALU_ADD, 32'h1000, 0, off, 1);
        t.load_type = lt[i];
        t.dren = 1'b1;
        add_vec(t, 0, 32'h1000 + off, be_tab[i][off], 0, 32'h104, 32'h100, 0);
      end
    end
    // Two killed rows, then the same instruction alive
    t = ins(ALU_ADD, 3, 3, 0, 0);
    t.branch_instr = 1'b1;
    t.jump_instr = 1'b1;
    t.dren = 1'b1;
    t.dwen = 1'b1;
    add_vec(t, 1, 6, 0, 0, 32'h140, 32'h100, 3);
    add_vec(t, 1, 6, 0, 0, 32'h140, 32'h100, 3);
    add_vec(t, 0, 6, 0, 1, 32'h140, 32'h100, 3);
  endtask

  initial begin
    int          idx;
    int          received;
    int          cycle;
    int          first_push;
    int          credits;
    int          owed;
    logic        flush_next;
    logic [31:0] rnd;
    vec_t        e;
    CLK = 1'b0;
    nRST = 1'b0;
    flush = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    out_credit = 1'b0;
    build_vectors();
    repeat (16) @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);
    check("out_valid", out_valid, 0);
    check("in_credit", in_credit, 0);
    idx = 0;
    received = 0;
    cycle = 0;
    first_push = 0;
    credits = IN_DEPTH;
    owed = 0;
    flush_next = 1'b0;
    while (received < vecs.size()) begin
      @(negedge CLK);
      cycle++;
      if (cycle > MAX_CYCLES) begin
        $display("Timeout: results stopped arriving from the DUT");
        $display("Simulation finished: FAIL");
        $fatal(1);
      end
      if (out_valid) begin
        e = vecs[received];
        if (received == 0) begin
          check("latency", cycle - first_push, 2);
        end
        check("alu_out", out_result.alu_out, e.alu);
        check("store_wdata", out_result.store_wdata, e.st);
        check("byte_en", out_result.byte_en, e.be);
        check("branch_taken", out_result.branch_taken, e.taken);
        check("resolved_addr", out_result.resolved_addr, e.res);
        check("jump_addr", out_result.jump_addr, e.jmp);
        check("wen", out_result.wen, e.stim.wen & ~e.flush);
        check("dren", out_result.dren, e.stim.dren & ~e.flush);
        check("dwen", out_result.dwen, e.stim.dwen & ~e.flush);
        check("jump_instr", out_result.jump_instr, e.stim.jump_instr & ~e.flush);
        // Fields that pass through unchanged, killed or not
        check("load_type", out_result.load_type, e.stim.load_type);
        check("reg_rd", out_result.reg_rd, e.stim.reg_rd);
        check("branch_instr", out_result.branch_instr, e.stim.branch_instr);
        check("pc4", out_result.pc4, e.stim.pc4);
        received++;
        owed++;
      end
      out_credit = 1'b0;
      rnd = next_random();
      if (owed > 0 && rnd[16]) begin
        out_credit = 1'b1;
        owed--;
      end
      if (in_credit) begin
        credits++;
      end
      in_valid = 1'b0;
      flush = flush_next;
      flush_next = 1'b0;
      // A flushed row goes alone into an empty issue buffer
      if (!flush && idx < vecs.size() && credits > 0 &&
          (!vecs[idx].flush || credits == IN_DEPTH)) begin
        in_valid = 1'b1;
        in_instr = vecs[idx].stim;
        flush_next = vecs[idx].flush;
        if (idx == 0) begin
          first_push = cycle;
        end
        credits--;
        idx++;
      end
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
